// ==== source/bus_slave_pkg.sv ====
// ------------------------------
// bus slave package
// default sizes and types shared by the slave blocks
// ------------------------------
package bus_slave_pkg;

	// ------------------------------
	// bus side
	localparam int DEFAULT_BUS_WIDTH = 16; // bits per bus transfer
	localparam int DEFAULT_TRANSFERS_PER_WORD = 2; // msb halfword goes first
	localparam int DEFAULT_ADDRESS_DEPTH = 6; // small memory for simulation
	localparam bit DEFAULT_AUTOINCREMENT = 1'b1;

	// ------------------------------
	// strobe and ack timing
	// enable is delayed twice this, so the other signals settle before it is seen
	localparam int DEFAULT_SYNC_DEPTH = 10;
	localparam int DEFAULT_ACK_DELAY = 30; // extra stages on ack_valid

	// ------------------------------
	// playback side
	localparam int DEFAULT_PLAYBACK_START = 0; // first byte, inclusive
	localparam int DEFAULT_PLAYBACK_END = 64; // last byte, exclusive
	localparam int PLAYBACK_BYTE_WIDTH = 8;

	// one byte out of the gearbox port
	typedef logic [PLAYBACK_BYTE_WIDTH-1:0] playback_byte_t;

	// sequence error counter, wraps when full
	typedef logic [15:0] error_count_t;

endpackage

// ==== source/strobe_synchronizer.sv ====
// ------------------------------
// strobe synchronizer
// fixed-depth delay line for an asynchronous bus input
// ------------------------------
`timescale 1ns/1ps

module strobe_synchronizer #(
	parameter int DEPTH = 10, // at least 2, q_previous needs a stage before q
	parameter type payload_t = logic
) (
	input logic clock,
	input logic reset125,
	input payload_t d,
	output payload_t q,
	output payload_t q_previous
);

	payload_t stage [DEPTH];

	always_ff @(posedge clock) begin
		if (reset125) begin
			for (int i = 0; i < DEPTH; i++) begin
				stage[i] <= '0;
			end
		end else begin
			stage[0] <= d; // first stage may go metastable
			for (int i = 1; i < DEPTH; i++) begin
				stage[i] <= stage[i-1];
			end
		end
	end

	// the last two stages let the consumer check that the level is stable
	assign q = stage[DEPTH-1];
	assign q_previous = stage[DEPTH-2];

endmodule

// ==== source/bus_transfer_control.sv ====
// ------------------------------
// bus transfer control
// address, write and read sequences with auto-increment and error counts
// ------------------------------
`timescale 1ns/1ps

module bus_transfer_control #(
	parameter int BUS_WIDTH = 16,
	parameter int TRANSFERS_PER_WORD = 2,
	parameter int ADDRESS_DEPTH = 6, // no wider than BUS_WIDTH
	parameter int ACK_DELAY = 30,
	parameter bit AUTOINCREMENT = 1'b1
) (
	input logic clock,
	input logic reset125,
	input logic enable_q,
	input logic enable_previous,
	input logic read_q,
	input logic read_previous,
	input logic select_q,
	input logic select_previous,
	input logic [BUS_WIDTH-1:0] bus_q,
	input logic [TRANSFERS_PER_WORD*BUS_WIDTH-1:0] read_word,
	output logic [BUS_WIDTH-1:0] bus_out,
	output logic ack_valid,
	output logic write_strobe,
	output logic [TRANSFERS_PER_WORD*BUS_WIDTH-1:0] write_word,
	output logic [ADDRESS_DEPTH-1:0] word_address,
	output bus_slave_pkg::error_count_t read_errors,
	output bus_slave_pkg::error_count_t write_errors,
	output bus_slave_pkg::error_count_t address_errors
);
	import bus_slave_pkg::*;

	localparam int COUNT_WIDTH = (TRANSFERS_PER_WORD > 1) ? $clog2(TRANSFERS_PER_WORD) : 1;
	localparam logic [COUNT_WIDTH-1:0] LAST_HALF = COUNT_WIDTH'(TRANSFERS_PER_WORD - 1);

	typedef enum logic [1:0] {
		SEQ_IDLE, // waiting for a transfer
		SEQ_CAPTURED, // halfword taken, waiting for enable low
		SEQ_DONE // whole word finished
	} seq_state_t;

	seq_state_t read_state, write_state, address_state;
	logic [COUNT_WIDTH-1:0] read_count, write_count; // counts down from msb half
	logic [TRANSFERS_PER_WORD-1:0][BUS_WIDTH-1:0] write_halves;
	logic [ADDRESS_DEPTH-1:0] address_capture;
	logic pre_ack;
	logic [ACK_DELAY:0] ack_pipeline;

	// ------------------------------
	// decode, a level counts only when two stages agree
	logic enable_high, enable_low;
	logic read_high, read_low;
	logic select_high, select_low;
	logic read_accept, write_accept, address_accept;
	logic read_partial, write_partial, address_partial;
	logic [BUS_WIDTH-1:0] read_half;

	assign enable_high = enable_q && enable_previous;
	assign enable_low = !enable_q && !enable_previous;
	assign read_high = read_q && read_previous;
	assign read_low = !read_q && !read_previous;
	assign select_high = select_q && select_previous;
	assign select_low = !select_q && !select_previous;

	assign read_accept = enable_high && read_high;
	assign write_accept = enable_high && read_low && select_high;
	assign address_accept = enable_high && read_low && select_low;

	// a sequence is partial if it has started but not wrapped back
	assign read_partial = (read_state != SEQ_IDLE) || (read_count != LAST_HALF);
	assign write_partial = (write_state != SEQ_IDLE) || (write_count != LAST_HALF);
	assign address_partial = (address_state != SEQ_IDLE);

	assign read_half = read_word[read_count*BUS_WIDTH +: BUS_WIDTH];
	assign write_word = write_halves;

	// payload capture
	always_ff @(posedge clock) begin
		if (write_accept && write_state == SEQ_IDLE) begin
			write_halves[write_count] <= bus_q;
		end
		if (address_accept && address_state == SEQ_IDLE) begin
			address_capture <= bus_q[ADDRESS_DEPTH-1:0];
		end
	end

	// ------------------------------
	// sequence FSMs
	always_ff @(posedge clock) begin
		if (reset125) begin
			pre_ack <= 1'b0;
			write_strobe <= 1'b0;
			bus_out <= '0;
			word_address <= '0;
			read_state <= SEQ_IDLE;
			write_state <= SEQ_IDLE;
			address_state <= SEQ_IDLE;
			read_count <= LAST_HALF;
			write_count <= LAST_HALF;
			read_errors <= '0;
			write_errors <= '0;
			address_errors <= '0;
		end else begin
			pre_ack <= read_accept || write_accept || address_accept; // held while enable is
			write_strobe <= 1'b0;
			if (read_accept && read_state == SEQ_IDLE) begin
				read_state <= SEQ_CAPTURED;
				bus_out <= read_half;
			end
			if (write_accept && write_state == SEQ_IDLE) begin
				write_state <= SEQ_CAPTURED;
			end
			if (address_accept && address_state == SEQ_IDLE) begin
				address_state <= SEQ_CAPTURED;
			end
			if (enable_low) begin
				if (AUTOINCREMENT && (read_state == SEQ_DONE || write_state == SEQ_DONE)) begin
					word_address <= word_address + 1'b1;
				end
				// write transfer seen
				if (write_state != SEQ_IDLE) begin
					if (read_partial) begin
						read_state <= SEQ_IDLE;
						read_count <= LAST_HALF;
						read_errors <= read_errors + error_count_t'(1);
					end
					if (address_partial) begin
						address_state <= SEQ_IDLE;
						address_errors <= address_errors + error_count_t'(1);
					end
					if (write_state == SEQ_DONE) begin
						write_state <= SEQ_IDLE;
						write_count <= LAST_HALF;
					end else if (write_count == '0) begin
						write_state <= SEQ_DONE;
						write_strobe <= 1'b1; // word lands at the current address
					end else begin
						write_state <= SEQ_IDLE;
						write_count <= write_count - 1'b1;
					end
				end
				// read transfer seen
				if (read_state != SEQ_IDLE) begin
					if (write_partial) begin
						write_state <= SEQ_IDLE;
						write_count <= LAST_HALF;
						write_errors <= write_errors + error_count_t'(1);
					end
					if (address_partial) begin
						address_state <= SEQ_IDLE;
						address_errors <= address_errors + error_count_t'(1);
					end
					if (read_state == SEQ_DONE) begin
						read_state <= SEQ_IDLE;
						read_count <= LAST_HALF;
					end else if (read_count == '0) begin
						read_state <= SEQ_DONE;
					end else begin
						read_state <= SEQ_IDLE;
						read_count <= read_count - 1'b1;
					end
				end
				// address is a single transfer, done as soon as enable drops
				if (address_state != SEQ_IDLE) begin
					if (write_partial) begin
						write_state <= SEQ_IDLE;
						write_count <= LAST_HALF;
						write_errors <= write_errors + error_count_t'(1);
					end
					if (read_partial) begin
						read_state <= SEQ_IDLE;
						read_count <= LAST_HALF;
						read_errors <= read_errors + error_count_t'(1);
					end
					address_state <= SEQ_IDLE;
					word_address <= address_capture;
				end
			end
		end
	end

	// ------------------------------
	// ack delay line
	always_ff @(posedge clock) begin
		if (reset125) begin
			ack_pipeline <= '0;
		end else begin
			ack_pipeline <= {ack_pipeline[ACK_DELAY-1:0], pre_ack};
		end
	end

	assign ack_valid = ack_pipeline[ACK_DELAY];

endmodule

// ==== source/gearbox_ram.sv ====
// ------------------------------
// gearbox ram
// word-wide bus port and byte-wide playback port on one memory
// ------------------------------
`timescale 1ns/1ps

module gearbox_ram #(
	parameter int WORD_WIDTH = 32,
	parameter int ADDRESS_DEPTH = 6,
	localparam int BYTE_ADDRESS_DEPTH =
		ADDRESS_DEPTH + $clog2(WORD_WIDTH / bus_slave_pkg::PLAYBACK_BYTE_WIDTH)
) (
	input logic clock,
	input logic [ADDRESS_DEPTH-1:0] word_address,
	input logic [WORD_WIDTH-1:0] write_word,
	input logic write_strobe,
	output logic [WORD_WIDTH-1:0] read_word,
	input logic [BYTE_ADDRESS_DEPTH-1:0] byte_address,
	output bus_slave_pkg::playback_byte_t playback_byte
);
	import bus_slave_pkg::*;

	localparam int BYTES_PER_WORD = WORD_WIDTH / PLAYBACK_BYTE_WIDTH;
	localparam int BYTE_SELECT_WIDTH = $clog2(BYTES_PER_WORD);

	logic [WORD_WIDTH-1:0] memory [2**ADDRESS_DEPTH];

	// split the byte address, low bits pick the byte inside a word
	logic [ADDRESS_DEPTH-1:0] playback_word_index;
	logic [BYTE_SELECT_WIDTH-1:0] playback_byte_index;
	logic [WORD_WIDTH-1:0] playback_word;

	assign playback_word_index = byte_address[BYTE_ADDRESS_DEPTH-1:BYTE_SELECT_WIDTH];
	assign playback_byte_index = byte_address[BYTE_SELECT_WIDTH-1:0];
	assign playback_word = memory[playback_word_index];

	// ------------------------------
	// port A, bus side
	always_ff @(posedge clock) begin
		if (write_strobe) begin
			memory[word_address] <= write_word;
		end
	end

	assign read_word = memory[word_address]; // async read

	// ------------------------------
	// port B, one byte per cycle
	always_ff @(posedge clock) begin
		playback_byte <= playback_word[playback_byte_index*PLAYBACK_BYTE_WIDTH +: PLAYBACK_BYTE_WIDTH];
	end

endmodule

// ==== source/playback_sequencer.sv ====
// ------------------------------
// playback sequencer
// loops the byte address and marks the start of each pass
// ------------------------------
`timescale 1ns/1ps

module playback_sequencer #(
	parameter int BYTE_ADDRESS_DEPTH = 8,
	parameter int PLAYBACK_START = 0, // inclusive
	parameter int PLAYBACK_END = 64 // exclusive
) (
	input logic clock,
	input logic reset125,
	input logic sync_in,
	output logic [BYTE_ADDRESS_DEPTH-1:0] byte_address,
	output logic sync_out
);

	localparam logic [BYTE_ADDRESS_DEPTH-1:0] FIRST_BYTE = BYTE_ADDRESS_DEPTH'(PLAYBACK_START);
	localparam logic [BYTE_ADDRESS_DEPTH-1:0] LAST_BYTE = BYTE_ADDRESS_DEPTH'(PLAYBACK_END - 1);

	logic restart_mark; // high while byte_address sits on the first byte after a restart

	always_ff @(posedge clock) begin
		if (reset125) begin
			byte_address <= FIRST_BYTE;
			restart_mark <= 1'b0;
		end else if (sync_in || byte_address == LAST_BYTE) begin
			byte_address <= FIRST_BYTE;
			restart_mark <= 1'b1;
		end else begin
			byte_address <= byte_address + 1'b1;
			restart_mark <= 1'b0;
		end
	end

	// ------------------------------
	// memory read adds one cycle, so the mark follows it by one
	always_ff @(posedge clock) begin
		if (reset125) begin
			sync_out <= 1'b0;
		end else begin
			sync_out <= restart_mark;
		end
	end

endmodule

// ==== source/bus_slave_top.sv ====
// ------------------------------
// bus slave top
// strobe synchronizers, transfer control, memory and playback
// ------------------------------
`timescale 1ns/1ps

module bus_slave_top #(
	parameter int BUS_WIDTH = bus_slave_pkg::DEFAULT_BUS_WIDTH,
	parameter int TRANSFERS_PER_WORD = bus_slave_pkg::DEFAULT_TRANSFERS_PER_WORD,
	parameter int ADDRESS_DEPTH = bus_slave_pkg::DEFAULT_ADDRESS_DEPTH,
	parameter int SYNC_DEPTH = bus_slave_pkg::DEFAULT_SYNC_DEPTH,
	parameter int ACK_DELAY = bus_slave_pkg::DEFAULT_ACK_DELAY,
	parameter bit AUTOINCREMENT = bus_slave_pkg::DEFAULT_AUTOINCREMENT,
	parameter int PLAYBACK_START = bus_slave_pkg::DEFAULT_PLAYBACK_START,
	parameter int PLAYBACK_END = bus_slave_pkg::DEFAULT_PLAYBACK_END
) (
	input logic clock,
	input logic reset125,
	input logic enable, // 1 = transfer active
	input logic read, // 0 = write, 1 = read
	input logic register_select, // 0 = address, 1 = data
	input logic [BUS_WIDTH-1:0] bus_in,
	input logic sync_in,
	output logic [BUS_WIDTH-1:0] bus_out,
	output logic ack_valid,
	output bus_slave_pkg::playback_byte_t playback_byte,
	output logic sync_out,
	output bus_slave_pkg::error_count_t read_errors,
	output bus_slave_pkg::error_count_t write_errors,
	output bus_slave_pkg::error_count_t address_errors
);
	import bus_slave_pkg::*;

	localparam int WORD_WIDTH = TRANSFERS_PER_WORD * BUS_WIDTH;
	localparam int BYTE_ADDRESS_DEPTH = ADDRESS_DEPTH + $clog2(WORD_WIDTH / PLAYBACK_BYTE_WIDTH);

	typedef logic [BUS_WIDTH-1:0] bus_word_t;

	logic enable_q, enable_previous;
	logic read_q, read_previous;
	logic select_q, select_previous;
	bus_word_t bus_q;
	logic [WORD_WIDTH-1:0] read_word, write_word;
	logic write_strobe;
	logic [ADDRESS_DEPTH-1:0] word_address;
	logic [BYTE_ADDRESS_DEPTH-1:0] byte_address;

	// ------------------------------
	// input synchronizers, enable runs twice as deep
	strobe_synchronizer #(.DEPTH(2*SYNC_DEPTH), .payload_t(logic)) enable_sync (
		.clock(clock), .reset125(reset125), .d(enable),
		.q(enable_q), .q_previous(enable_previous));

	strobe_synchronizer #(.DEPTH(SYNC_DEPTH), .payload_t(logic)) read_sync (
		.clock(clock), .reset125(reset125), .d(read),
		.q(read_q), .q_previous(read_previous));

	strobe_synchronizer #(.DEPTH(SYNC_DEPTH), .payload_t(logic)) select_sync (
		.clock(clock), .reset125(reset125), .d(register_select),
		.q(select_q), .q_previous(select_previous));

	strobe_synchronizer #(.DEPTH(SYNC_DEPTH), .payload_t(bus_word_t)) bus_sync (
		.clock(clock), .reset125(reset125), .d(bus_in),
		.q(bus_q), .q_previous());

	// ------------------------------
	bus_transfer_control #(
		.BUS_WIDTH(BUS_WIDTH), .TRANSFERS_PER_WORD(TRANSFERS_PER_WORD),
		.ADDRESS_DEPTH(ADDRESS_DEPTH), .ACK_DELAY(ACK_DELAY), .AUTOINCREMENT(AUTOINCREMENT)
	) control (
		.clock(clock), .reset125(reset125),
		.enable_q(enable_q), .enable_previous(enable_previous),
		.read_q(read_q), .read_previous(read_previous),
		.select_q(select_q), .select_previous(select_previous),
		.bus_q(bus_q), .read_word(read_word),
		.bus_out(bus_out), .ack_valid(ack_valid),
		.write_strobe(write_strobe), .write_word(write_word), .word_address(word_address),
		.read_errors(read_errors), .write_errors(write_errors),
		.address_errors(address_errors));

	gearbox_ram #(.WORD_WIDTH(WORD_WIDTH), .ADDRESS_DEPTH(ADDRESS_DEPTH)) ram (
		.clock(clock), .word_address(word_address), .write_word(write_word),
		.write_strobe(write_strobe), .read_word(read_word),
		.byte_address(byte_address), .playback_byte(playback_byte));

	playback_sequencer #(
		.BYTE_ADDRESS_DEPTH(BYTE_ADDRESS_DEPTH),
		.PLAYBACK_START(PLAYBACK_START), .PLAYBACK_END(PLAYBACK_END)
	) sequencer (
		.clock(clock), .reset125(reset125), .sync_in(sync_in),
		.byte_address(byte_address), .sync_out(sync_out));

endmodule

// ==== testbench/bus_master_tasks.svh ====
// ------------------------------
// bus master tasks
// bus transfers, bounded waits and value compare
// ------------------------------
`ifndef BUS_MASTER_TASKS_SVH
`define BUS_MASTER_TASKS_SVH

localparam int ACK_TIMEOUT = 200; // ack path is roughly 55 cycles deep
localparam int SYNC_TIMEOUT = 200; // one playback pass is 64 cycles

task automatic compare_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
	if (actual !== expected) begin
		$display("MISMATCH %s: actual 0x%h, expected 0x%h", name, actual, expected);
		stop_with_failure();
	end
endtask

task automatic idle_gap;
	repeat ($urandom % 4) @(posedge clock); // random spacing between transfers
endtask

task automatic wait_for_ack(input logic level);
	int cycles = 0;
	while (ack_valid !== level) begin
		if (cycles == ACK_TIMEOUT) begin
			$display("ack_valid did not reach %0b within %0d cycles", level, ACK_TIMEOUT);
			stop_with_failure();
		end
		@(negedge clock);
		cycles++;
	end
endtask

task automatic wait_for_sync_out;
	int cycles = 0;
	@(negedge clock); // sample between edges
	while (sync_out !== 1'b1) begin
		if (cycles == SYNC_TIMEOUT) begin
			$display("sync_out never went high within %0d cycles", SYNC_TIMEOUT);
			stop_with_failure();
		end
		@(negedge clock);
		cycles++;
	end
endtask

// one transfer, full enable/ack handshake
task automatic bus_transfer(input logic is_read, input logic is_data,
		input logic [15:0] value, output logic [15:0] response);
	idle_gap();
	@(posedge clock);
	read <= is_read;
	register_select <= is_data;
	bus_in <= value;
	enable <= 1'b1; // enable runs deeper, the rest settles first
	wait_for_ack(1'b1);
	response = bus_out; // held from ack on
	@(posedge clock);
	enable <= 1'b0;
	wait_for_ack(1'b0);
endtask

`endif

// ==== testbench/bus_slave_tb.sv ====
// ------------------------------
// bus slave testbench
// data-file driven transfers, error counts and playback
// ------------------------------
`timescale 1ns/1ps

module bus_slave_tb;
	import bus_slave_pkg::*;

	localparam int FIELDS = 5; // op code, then four arguments
	localparam int MAX_OPS = 64;
	localparam int MEMORY_WORDS = 2**DEFAULT_ADDRESS_DEPTH;
	localparam int BYTES_PER_WORD = 4;
	localparam int PLAYBACK_BYTES = DEFAULT_PLAYBACK_END - DEFAULT_PLAYBACK_START;

	logic clock;
	logic reset125;
	logic enable, read, register_select, sync_in;
	logic [15:0] bus_in, bus_out;
	logic ack_valid, sync_out;
	playback_byte_t playback_byte;
	error_count_t read_errors, write_errors, address_errors;

	logic [31:0] testdata [MAX_OPS*FIELDS];
	logic [31:0] model [MEMORY_WORDS]; // words the master has written
	int model_address; // follows the auto-increment

	`include "bus_master_tasks.svh"

	bus_slave_top DUT (
		.clock(clock), .reset125(reset125), .enable(enable), .read(read),
		.register_select(register_select), .bus_in(bus_in), .sync_in(sync_in),
		.bus_out(bus_out), .ack_valid(ack_valid), .playback_byte(playback_byte),
		.sync_out(sync_out), .read_errors(read_errors), .write_errors(write_errors),
		.address_errors(address_errors));

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	task automatic stop_with_failure;
		$display("Some tests failed");
		$fatal(1, "run stopped at the first failure");
	endtask

	// ------------------------------
	// word level operations
	task automatic write_data_word(input logic [31:0] word);
		logic [15:0] response;
		bus_transfer(1'b0, 1'b1, word[31:16], response); // msb half first
		bus_transfer(1'b0, 1'b1, word[15:0], response);
		model[model_address % MEMORY_WORDS] = word;
		model_address++;
	endtask

	task automatic read_data_word(input logic [31:0] expected);
		logic [15:0] half;
		bus_transfer(1'b1, 1'b1, 16'h0000, half);
		compare_value("bus_out high half", half, expected[31:16]);
		bus_transfer(1'b1, 1'b1, 16'h0000, half);
		compare_value("bus_out low half", half, expected[15:0]);
		model_address++;
	endtask

	// bytes in address order, lsb of each word first
	task automatic check_playback;
		int byte_index;
		@(posedge clock);
		sync_in <= 1'b1;
		@(posedge clock);
		sync_in <= 1'b0;
		@(posedge clock); // restart takes effect on this edge
		wait_for_sync_out();
		for (int i = 0; i <= PLAYBACK_BYTES; i++) begin
			byte_index = DEFAULT_PLAYBACK_START + (i % PLAYBACK_BYTES);
			compare_value("playback_byte", playback_byte,
				(model[byte_index / BYTES_PER_WORD] >> (8 * (byte_index % BYTES_PER_WORD)))
				& 32'hff);
			compare_value("sync_out", sync_out, (i % PLAYBACK_BYTES) == 0);
			@(negedge clock);
		end
	endtask

	// ------------------------------
	initial begin
		logic [31:0] op;
		logic [31:0] args [4];
		logic [15:0] response;
		int index;
		enable = 1'b0;
		read = 1'b0;
		register_select = 1'b0;
		bus_in = '0;
		sync_in = 1'b0;
		reset125 = 1'b1;
		model_address = 0;
		index = 0;
		void'($urandom(83));
		$readmemh("testbench/bus_slave_testdata.txt", testdata);
		repeat (8) @(posedge clock);
		reset125 <= 1'b0;
		@(negedge clock);
		compare_value("ack_valid", ack_valid, 0);
		compare_value("sync_out", sync_out, 0);
		compare_value("bus_out", bus_out, 0);
		compare_value("read_errors", read_errors, 0);
		compare_value("write_errors", write_errors, 0);
		compare_value("address_errors", address_errors, 0);
		op = testdata[0];
		while (op !== 32'h0) begin
			for (int i = 0; i < 4; i++) begin
				args[i] = testdata[index*FIELDS + 1 + i];
			end
			case (op)
				32'h1: begin
					bus_transfer(1'b0, 1'b0, args[0][15:0], response);
					model_address = args[0] % MEMORY_WORDS;
				end
				32'h2: write_data_word(args[0]);
				32'h3: read_data_word(args[0]);
				32'h4: begin // kind 0 address, 1 write half, 2 read half
					bus_transfer(args[0] == 2, args[0] != 0, 16'h0000, response);
					if (args[0] == 0) begin
						model_address = 0;
					end
					compare_value("read_errors", read_errors, args[1]);
					compare_value("write_errors", write_errors, args[2]);
					compare_value("address_errors", address_errors, args[3]);
				end
				32'h5: check_playback();
				default: begin
					$display("unknown operation 0x%h at data file entry %0d", op, index);
					stop_with_failure();
				end
			endcase
			index++;
			op = testdata[index*FIELDS];
		end
		$display("All tests passed");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+testbench
source/bus_slave_pkg.sv
source/strobe_synchronizer.sv
source/bus_transfer_control.sv
source/gearbox_ram.sv
source/playback_sequencer.sv
source/bus_slave_top.sv
testbench/bus_slave_tb.sv

// ==== Bender.yml ====
package:
  name: bus_slave

sources:
  - source/bus_slave_pkg.sv
  - source/strobe_synchronizer.sv
  - source/bus_transfer_control.sv
  - source/gearbox_ram.sv
  - source/playback_sequencer.sv
  - source/bus_slave_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/bus_slave_tb.sv

// ==== testbench/bus_slave_testdata.txt ====
// op arg0 arg1 arg2 arg3 in hex; op 1 address, 2 write word, 3 read word, 5 playback, 0 end
// op 4 partial transfer: arg0 kind (0 address, 1 write, 2 read), then read/write/address errors
1 00000000 0 0 0
2 03020100 0 0 0
2 13121110 0 0 0
2 23222120 0 0 0
2 33323130 0 0 0
2 43424140 0 0 0
2 53525150 0 0 0
2 63626160 0 0 0
2 73727170 0 0 0
2 83828180 0 0 0
2 93929190 0 0 0
2 a3a2a1a0 0 0 0
2 b3b2b1b0 0 0 0
2 c3c2c1c0 0 0 0
2 d3d2d1d0 0 0 0
2 e3e2e1e0 0 0 0
2 f3f2f1f0 0 0 0
1 00000000 0 0 0
3 03020100 0 0 0
3 13121110 0 0 0
4 00000001 0 0 0
4 00000002 0 1 0
4 00000001 1 1 0
4 00000000 1 2 0
5 00000000 0 0 0
0 00000000 0 0 0
